//--- common/soc_pkg.sv
package soc_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;

    typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;   // Byte address
    typedef logic [AXI_DATA_W-1:0]   axi_data_t;
    typedef logic [AXI_DATA_W/8-1:0] axi_strb_t;   // One bit per byte lane
    typedef logic [1:0]              axi_resp_t;
    typedef logic [7:0]              uart_byte_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    typedef enum logic [1:0] {
        DEV_SRAM,
        DEV_UART,
        DEV_CLINT,
        DEV_NONE                                    // No window hit
    } dev_sel_t;

    localparam axi_addr_t SRAM_BASE  = 32'h8000_0000;
    localparam axi_addr_t SRAM_MASK  = 32'hF000_0000;  // Top nibble 4'b1000
    localparam axi_addr_t UART_ADDR  = 32'hA000_03F8;  // THR, exact match only
    localparam axi_addr_t CLINT_BASE = 32'hA000_0048;  // mtime lo, hi at +4
    localparam axi_addr_t CLINT_MASK = 32'hFFFF_FFF8;

    localparam int SRAM_WORDS = 1024;
    localparam int SRAM_AW    = $clog2(SRAM_WORDS);    // Word index width

    localparam axi_data_t UART_STATUS = 32'h0000_0020; // THR empty, bit 5

    // Address map lookup, shared by both muxes
    function automatic dev_sel_t addr_decode(input axi_addr_t addr);
        if ((addr & SRAM_MASK) == SRAM_BASE)
            return DEV_SRAM;
        if (addr == UART_ADDR)
            return DEV_UART;
        if ((addr & CLINT_MASK) == CLINT_BASE)
            return DEV_CLINT;
        return DEV_NONE;
    endfunction

endpackage

//--- xbar/axil_read_mux.sv
`timescale 1ns/1ps

module axil_read_mux
    import soc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fetch_arvalid,
    input  axi_addr_t fetch_araddr,
    output logic      fetch_arready,
    output logic      fetch_rvalid,
    output axi_data_t fetch_rdata,
    output axi_resp_t fetch_rresp,
    input  logic      fetch_rready,
    input  logic      lsu_arvalid,
    input  axi_addr_t lsu_araddr,
    output logic      lsu_arready,
    output logic      lsu_rvalid,
    output axi_data_t lsu_rdata,
    output axi_resp_t lsu_rresp,
    input  logic      lsu_rready,
    output logic      sram_arvalid,
    output axi_addr_t sram_araddr,
    input  logic      sram_arready,
    input  logic      sram_rvalid,
    input  axi_data_t sram_rdata,
    input  axi_resp_t sram_rresp,
    output logic      sram_rready,
    output logic      uart_arvalid,
    output axi_addr_t uart_araddr,
    input  logic      uart_arready,
    input  logic      uart_rvalid,
    input  axi_data_t uart_rdata,
    input  axi_resp_t uart_rresp,
    output logic      uart_rready,
    output logic      clint_arvalid,
    output axi_addr_t clint_araddr,
    input  logic      clint_arready,
    input  logic      clint_rvalid,
    input  axi_data_t clint_rdata,
    input  axi_resp_t clint_rresp,
    output logic      clint_rready
);

    typedef enum logic [1:0] {RD_IDLE, RD_FWD, RD_WAIT, RD_ERR} rd_state_t;

    rd_state_t state;
    logic      prio_lsu;        // Next tie goes to lsu
    logic      gnt_lsu;         // Owner of the read in flight
    dev_sel_t  dev_q;           // Decoded once at accept
    axi_addr_t addr_q;

    logic      pick_lsu;
    logic      accept;
    axi_addr_t req_addr;
    dev_sel_t  req_dev;
    logic      dev_arready;
    logic      dev_rvalid;
    axi_data_t dev_rdata;
    axi_resp_t dev_rresp;
    logic      rsp_valid;
    logic      rsp_ready;
    axi_data_t rsp_data;
    axi_resp_t rsp_resp;

    assign pick_lsu      = lsu_arvalid && (!fetch_arvalid || prio_lsu);
    assign accept        = (state == RD_IDLE) && (fetch_arvalid || lsu_arvalid);
    assign fetch_arready = accept && !pick_lsu;
    assign lsu_arready   = accept && pick_lsu;
    assign req_addr      = pick_lsu ? lsu_araddr : fetch_araddr;
    assign req_dev       = addr_decode(req_addr);

    assign sram_arvalid  = (state == RD_FWD) && (dev_q == DEV_SRAM);
    assign uart_arvalid  = (state == RD_FWD) && (dev_q == DEV_UART);
    assign clint_arvalid = (state == RD_FWD) && (dev_q == DEV_CLINT);
    assign sram_araddr   = addr_q;
    assign uart_araddr   = addr_q;
    assign clint_araddr  = addr_q;

    // Selected device back towards the manager
    assign dev_arready = (dev_q == DEV_SRAM) ? sram_arready :
                         (dev_q == DEV_UART) ? uart_arready : clint_arready;
    assign dev_rvalid  = (dev_q == DEV_SRAM) ? sram_rvalid :
                         (dev_q == DEV_UART) ? uart_rvalid : clint_rvalid;
    assign dev_rdata   = (dev_q == DEV_SRAM) ? sram_rdata :
                         (dev_q == DEV_UART) ? uart_rdata : clint_rdata;
    assign dev_rresp   = (dev_q == DEV_SRAM) ? sram_rresp :
                         (dev_q == DEV_UART) ? uart_rresp : clint_rresp;

    assign rsp_valid = (state == RD_ERR) || ((state == RD_WAIT) && dev_rvalid);
    assign rsp_data  = (state == RD_ERR) ? '0 : dev_rdata;        // Zero data on DECERR
    assign rsp_resp  = (state == RD_ERR) ? RESP_DECERR : dev_rresp;
    assign rsp_ready = gnt_lsu ? lsu_rready : fetch_rready;

    assign fetch_rvalid = rsp_valid && !gnt_lsu;
    assign lsu_rvalid   = rsp_valid && gnt_lsu;
    assign fetch_rdata  = rsp_data;
    assign lsu_rdata    = rsp_data;
    assign fetch_rresp  = rsp_resp;
    assign lsu_rresp    = rsp_resp;

    assign sram_rready  = (state == RD_WAIT) && (dev_q == DEV_SRAM) && rsp_ready;
    assign uart_rready  = (state == RD_WAIT) && (dev_q == DEV_UART) && rsp_ready;
    assign clint_rready = (state == RD_WAIT) && (dev_q == DEV_CLINT) && rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RD_IDLE;
            prio_lsu <= 1'b0;                // Fetch wins first tie
            gnt_lsu  <= 1'b0;
            dev_q    <= DEV_NONE;
        end else begin
            unique case (state)
                RD_IDLE: if (accept) begin
                    gnt_lsu  <= pick_lsu;
                    prio_lsu <= !pick_lsu;   // Other side next time
                    dev_q    <= req_dev;
                    state    <= (req_dev == DEV_NONE) ? RD_ERR : RD_FWD;
                end
                RD_FWD: if (dev_arready) state <= RD_WAIT;
                default: if (rsp_valid && rsp_ready) state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) addr_q <= req_addr;     // Held for the device ar phase
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({sram_arvalid, uart_arvalid, clint_arvalid}));

    // A fresh grant never leaks a response to the other manager
    assert property (@(posedge clk) disable iff (rst)
        lsu_arvalid && lsu_arready |=> !fetch_rvalid);
    assert property (@(posedge clk) disable iff (rst)
        fetch_arvalid && fetch_arready |=> !lsu_rvalid);

endmodule

//--- xbar/axil_write_mux.sv
`timescale 1ns/1ps

module axil_write_mux
    import soc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      lsu_awvalid,
    input  axi_addr_t lsu_awaddr,
    output logic      lsu_awready,
    input  logic      lsu_wvalid,
    input  axi_data_t lsu_wdata,
    input  axi_strb_t lsu_wstrb,
    output logic      lsu_wready,
    output logic      lsu_bvalid,
    output axi_resp_t lsu_bresp,
    input  logic      lsu_bready,
    output logic      sram_awvalid,
    output axi_addr_t sram_awaddr,
    input  logic      sram_awready,
    output logic      sram_wvalid,
    output axi_data_t sram_wdata,
    output axi_strb_t sram_wstrb,
    input  logic      sram_wready,
    input  logic      sram_bvalid,
    input  axi_resp_t sram_bresp,
    output logic      sram_bready,
    output logic      uart_awvalid,
    output axi_addr_t uart_awaddr,
    input  logic      uart_awready,
    output logic      uart_wvalid,
    output axi_data_t uart_wdata,
    output axi_strb_t uart_wstrb,
    input  logic      uart_wready,
    input  logic      uart_bvalid,
    input  axi_resp_t uart_bresp,
    output logic      uart_bready,
    output logic      clint_awvalid,
    output axi_addr_t clint_awaddr,
    input  logic      clint_awready,
    output logic      clint_wvalid,
    output axi_data_t clint_wdata,
    output axi_strb_t clint_wstrb,
    input  logic      clint_wready,
    input  logic      clint_bvalid,
    input  axi_resp_t clint_bresp,
    output logic      clint_bready
);

    typedef enum logic [1:0] {WR_IDLE, WR_FWD, WR_WAIT, WR_ERR} wr_state_t;

    wr_state_t state;
    dev_sel_t  dev_q;
    axi_addr_t addr_q;
    axi_data_t data_q;
    axi_strb_t strb_q;

    logic      accept;
    dev_sel_t  req_dev;
    logic      dev_awready;
    logic      dev_wready;
    logic      dev_bvalid;
    axi_resp_t dev_bresp;

    assign accept      = (state == WR_IDLE) && lsu_awvalid && lsu_wvalid;  // aw and w paired
    assign lsu_awready = accept;
    assign lsu_wready  = accept;
    assign req_dev     = addr_decode(lsu_awaddr);

    assign sram_awvalid  = (state == WR_FWD) && (dev_q == DEV_SRAM);
    assign uart_awvalid  = (state == WR_FWD) && (dev_q == DEV_UART);
    assign clint_awvalid = (state == WR_FWD) && (dev_q == DEV_CLINT);
    assign sram_wvalid   = sram_awvalid;
    assign uart_wvalid   = uart_awvalid;
    assign clint_wvalid  = clint_awvalid;

    assign sram_awaddr  = addr_q;
    assign uart_awaddr  = addr_q;
    assign clint_awaddr = addr_q;
    assign sram_wdata   = data_q;
    assign uart_wdata   = data_q;
    assign clint_wdata  = data_q;
    assign sram_wstrb   = strb_q;
    assign uart_wstrb   = strb_q;
    assign clint_wstrb  = strb_q;

    assign dev_awready = (dev_q == DEV_SRAM) ? sram_awready :
                         (dev_q == DEV_UART) ? uart_awready : clint_awready;
    assign dev_wready  = (dev_q == DEV_SRAM) ? sram_wready :
                         (dev_q == DEV_UART) ? uart_wready : clint_wready;
    assign dev_bvalid  = (dev_q == DEV_SRAM) ? sram_bvalid :
                         (dev_q == DEV_UART) ? uart_bvalid : clint_bvalid;
    assign dev_bresp   = (dev_q == DEV_SRAM) ? sram_bresp :
                         (dev_q == DEV_UART) ? uart_bresp : clint_bresp;

    assign lsu_bvalid = (state == WR_ERR) || ((state == WR_WAIT) && dev_bvalid);
    assign lsu_bresp  = (state == WR_ERR) ? RESP_DECERR : dev_bresp;

    assign sram_bready  = (state == WR_WAIT) && (dev_q == DEV_SRAM) && lsu_bready;
    assign uart_bready  = (state == WR_WAIT) && (dev_q == DEV_UART) && lsu_bready;
    assign clint_bready = (state == WR_WAIT) && (dev_q == DEV_CLINT) && lsu_bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WR_IDLE;
            dev_q <= DEV_NONE;
        end else begin
            unique case (state)
                WR_IDLE: if (accept) begin
                    dev_q <= req_dev;
                    state <= (req_dev == DEV_NONE) ? WR_ERR : WR_FWD;  // Unmapped answered here
                end
                WR_FWD: if (dev_awready && dev_wready) state <= WR_WAIT;
                default: if (lsu_bvalid && lsu_bready) state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= lsu_awaddr;
            data_q <= lsu_wdata;
            strb_q <= lsu_wstrb;
        end
    end

    // Address and data always accepted as a pair
    assert property (@(posedge clk) disable iff (rst) lsu_awready == lsu_wready);

endmodule

//--- design/sram_dev.sv
`timescale 1ns/1ps

module sram_dev
    import soc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      arvalid,
    input  axi_addr_t araddr,
    output logic      arready,
    output logic      rvalid,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    input  logic      rready,
    input  logic      awvalid,
    input  axi_addr_t awaddr,
    output logic      awready,
    input  logic      wvalid,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    output logic      wready,
    output logic      bvalid,
    output axi_resp_t bresp,
    input  logic      bready
);

    axi_data_t mem [SRAM_WORDS];   // Word array, upper address bits wrap

    logic rd_go;
    logic wr_go;

    assign rd_go   = arvalid && !rvalid;             // One read pending at most
    assign wr_go   = awvalid && wvalid && !bvalid;
    assign arready = rd_go;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign rresp   = RESP_OKAY;
    assign bresp   = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (rd_go) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;      // Held until taken
            if (wr_go) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) rdata <= mem[araddr[SRAM_AW+1:2]];
        if (wr_go) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) mem[awaddr[SRAM_AW+1:2]][8*b +: 8] <= wdata[8*b +: 8];  // Lane merge
            end
        end
    end

endmodule

//--- design/clint_dev.sv
`timescale 1ns/1ps

module clint_dev
    import soc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      arvalid,
    input  axi_addr_t araddr,
    output logic      arready,
    output logic      rvalid,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    input  logic      rready,
    input  logic      awvalid,
    input  axi_addr_t awaddr,
    output logic      awready,
    input  logic      wvalid,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    output logic      wready,
    output logic      bvalid,
    output axi_resp_t bresp,
    input  logic      bready
);

    logic [63:0] mtime;
    logic [63:0] mtime_inc;
    axi_data_t   half_new;         // Written half after strobes
    logic        rd_go;
    logic        wr_go;

    assign rd_go     = arvalid && !rvalid;
    assign wr_go     = awvalid && wvalid && !bvalid;
    assign arready   = rd_go;
    assign awready   = wr_go;
    assign wready    = wr_go;
    assign rresp     = RESP_OKAY;
    assign bresp     = RESP_OKAY;
    assign mtime_inc = mtime + 64'd1;

    always_comb begin
        half_new = awaddr[2] ? mtime_inc[63:32] : mtime_inc[31:0];  // Offset 4 is hi
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) half_new[8*b +: 8] = wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime  <= '0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (wr_go && awaddr[2]) mtime <= {half_new, mtime_inc[31:0]};
            else if (wr_go) mtime <= {mtime_inc[63:32], half_new};
            else mtime <= mtime_inc;              // Free running tick
            if (rd_go) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
            if (wr_go) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) rdata <= araddr[2] ? mtime[63:32] : mtime[31:0];  // Sampled at accept
    end

endmodule

//--- design/uart_dev.sv
`timescale 1ns/1ps

module uart_dev
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       arvalid,
    input  axi_addr_t  araddr,
    output logic       arready,
    output logic       rvalid,
    output axi_data_t  rdata,
    output axi_resp_t  rresp,
    input  logic       rready,
    input  logic       awvalid,
    input  axi_addr_t  awaddr,
    output logic       awready,
    input  logic       wvalid,
    input  axi_data_t  wdata,
    input  axi_strb_t  wstrb,
    output logic       wready,
    output logic       bvalid,
    output axi_resp_t  bresp,
    input  logic       bready,
    output logic       tx_valid,
    output uart_byte_t tx_data
);

    logic rd_go;
    logic wr_go;

    assign rd_go   = arvalid && !rvalid;
    assign wr_go   = awvalid && wvalid && !bvalid;   // bvalid spaces out writes
    assign arready = rd_go;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign rresp   = RESP_OKAY;
    assign bresp   = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            if (rd_go) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
            if (wr_go) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            tx_valid <= wr_go && wstrb[0] && (awaddr == UART_ADDR);  // Byte 0 lane only
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go && wstrb[0]) tx_data <= wdata[7:0];            // THR
        if (rd_go) rdata <= (araddr == UART_ADDR) ? UART_STATUS : '0;
    end

    // Strobe lasts exactly one cycle
    assert property (@(posedge clk) disable iff (rst) tx_valid |=> !tx_valid);

endmodule

//--- design/soc_top.sv
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_arvalid,
    input  axi_addr_t  fetch_araddr,
    output logic       fetch_arready,
    output logic       fetch_rvalid,
    output axi_data_t  fetch_rdata,
    output axi_resp_t  fetch_rresp,
    input  logic       fetch_rready,
    input  logic       lsu_arvalid,
    input  axi_addr_t  lsu_araddr,
    output logic       lsu_arready,
    output logic       lsu_rvalid,
    output axi_data_t  lsu_rdata,
    output axi_resp_t  lsu_rresp,
    input  logic       lsu_rready,
    input  logic       lsu_awvalid,
    input  axi_addr_t  lsu_awaddr,
    output logic       lsu_awready,
    input  logic       lsu_wvalid,
    input  axi_data_t  lsu_wdata,
    input  axi_strb_t  lsu_wstrb,
    output logic       lsu_wready,
    output logic       lsu_bvalid,
    output axi_resp_t  lsu_bresp,
    input  logic       lsu_bready,
    output logic       uart_tx_valid,
    output uart_byte_t uart_tx_data
);

    // Device side, read channel from the read mux
    logic      sram_arvalid, uart_arvalid, clint_arvalid;
    axi_addr_t sram_araddr, uart_araddr, clint_araddr;
    logic      sram_arready, uart_arready, clint_arready;
    logic      sram_rvalid, uart_rvalid, clint_rvalid;
    axi_data_t sram_rdata, uart_rdata, clint_rdata;
    axi_resp_t sram_rresp, uart_rresp, clint_rresp;
    logic      sram_rready, uart_rready, clint_rready;
    // Write channel from the write mux
    logic      sram_awvalid, uart_awvalid, clint_awvalid;
    axi_addr_t sram_awaddr, uart_awaddr, clint_awaddr;
    logic      sram_awready, uart_awready, clint_awready;
    logic      sram_wvalid, uart_wvalid, clint_wvalid;
    axi_data_t sram_wdata, uart_wdata, clint_wdata;
    axi_strb_t sram_wstrb, uart_wstrb, clint_wstrb;
    logic      sram_wready, uart_wready, clint_wready;
    logic      sram_bvalid, uart_bvalid, clint_bvalid;
    axi_resp_t sram_bresp, uart_bresp, clint_bresp;
    logic      sram_bready, uart_bready, clint_bready;

    axil_read_mux read_mux_u0 (.*);       // Port names match the wires
    axil_write_mux write_mux_u0 (.*);

    sram_dev sram_u0 (
        .clk(clk), .rst(rst),
        .arvalid(sram_arvalid), .araddr(sram_araddr), .arready(sram_arready),
        .rvalid(sram_rvalid), .rdata(sram_rdata), .rresp(sram_rresp), .rready(sram_rready),
        .awvalid(sram_awvalid), .awaddr(sram_awaddr), .awready(sram_awready),
        .wvalid(sram_wvalid), .wdata(sram_wdata), .wstrb(sram_wstrb), .wready(sram_wready),
        .bvalid(sram_bvalid), .bresp(sram_bresp), .bready(sram_bready)
    );

    uart_dev uart_u0 (
        .clk(clk), .rst(rst),
        .arvalid(uart_arvalid), .araddr(uart_araddr), .arready(uart_arready),
        .rvalid(uart_rvalid), .rdata(uart_rdata), .rresp(uart_rresp), .rready(uart_rready),
        .awvalid(uart_awvalid), .awaddr(uart_awaddr), .awready(uart_awready),
        .wvalid(uart_wvalid), .wdata(uart_wdata), .wstrb(uart_wstrb), .wready(uart_wready),
        .bvalid(uart_bvalid), .bresp(uart_bresp), .bready(uart_bready),
        .tx_valid(uart_tx_valid), .tx_data(uart_tx_data)     // Straight to top pins
    );

    clint_dev clint_u0 (
        .clk(clk), .rst(rst),
        .arvalid(clint_arvalid), .araddr(clint_araddr), .arready(clint_arready),
        .rvalid(clint_rvalid), .rdata(clint_rdata), .rresp(clint_rresp),
        .rready(clint_rready),
        .awvalid(clint_awvalid), .awaddr(clint_awaddr), .awready(clint_awready),
        .wvalid(clint_wvalid), .wdata(clint_wdata), .wstrb(clint_wstrb),
        .wready(clint_wready),
        .bvalid(clint_bvalid), .bresp(clint_bresp), .bready(clint_bready)
    );

endmodule

//--- bench/tb_soc_top.sv
`timescale 1ns/1ps

module tb_soc_top
    import soc_pkg::*;
();

    localparam int NUM_PATS   = 20;                     // Lines in the pattern file
    localparam int FIELDS     = 8;                      // Words per pattern line
    localparam int MAX_CYCLES = NUM_PATS * 20 + 100;

    logic       clk;
    logic       rst;
    logic       fetch_arvalid;
    axi_addr_t  fetch_araddr;
    logic       fetch_arready;
    logic       fetch_rvalid;
    axi_data_t  fetch_rdata;
    axi_resp_t  fetch_rresp;
    logic       fetch_rready;
    logic       lsu_arvalid;
    axi_addr_t  lsu_araddr;
    logic       lsu_arready;
    logic       lsu_rvalid;
    axi_data_t  lsu_rdata;
    axi_resp_t  lsu_rresp;
    logic       lsu_rready;
    logic       lsu_awvalid;
    axi_addr_t  lsu_awaddr;
    logic       lsu_awready;
    logic       lsu_wvalid;
    axi_data_t  lsu_wdata;
    axi_strb_t  lsu_wstrb;
    logic       lsu_wready;
    logic       lsu_bvalid;
    axi_resp_t  lsu_bresp;
    logic       lsu_bready;
    logic       uart_tx_valid;
    uart_byte_t uart_tx_data;

    logic [31:0] pats [NUM_PATS*FIELDS];                // Flat copy of the pattern file
    logic [31:0] lcg_state;
    int          errors   = 0;
    int          passed   = 0;
    int          failed   = 0;
    int          cycles   = 0;
    int          tx_count = 0;                          // UART strobes seen so far
    uart_byte_t  tx_last;
    int          idx;

    soc_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                          // 4 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // UART strobe monitor, samples mid cycle
    initial begin
        forever begin
            @(posedge clk);
            #3;
            if (!rst && uart_tx_valid) begin
                tx_count++;
                tx_last = uart_tx_data;
            end
        end
    end

    function automatic int next_hold();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[17:16]);                  // 0 to 3 stall cycles
    endfunction

    function automatic logic [31:0] pat_field(input int n, input int f);
        return pats[n*FIELDS + f];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;                                             // Drive point
    endtask

    task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp,
                              input axi_data_t span);
        if ($isunknown(got) || got < exp || got - exp > span) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %08h expected %08h (+%0d)",
                     $time, name, got, exp, span);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_tx(input logic want, input uart_byte_t exp_byte, input int tx_before);
        int expected;
        expected = want ? tx_before + 1 : tx_before;
        if (tx_count != expected) begin
            errors++;
            $display("CHECK FAILED t=%0t uart_tx_valid pulses got %0d expected %0d",
                     $time, tx_count - tx_before, expected - tx_before);
        end else if (want) begin
            check_byte("uart_tx_data", tx_last, exp_byte);
        end
    endtask

    task automatic read_txn(input logic use_lsu, input axi_addr_t addr, input int hold,
                            output axi_data_t data, output axi_resp_t resp);
        logic seen;
        if (use_lsu) begin
            lsu_arvalid = 1'b1;
            lsu_araddr  = addr;
        end else begin
            fetch_arvalid = 1'b1;
            fetch_araddr  = addr;
        end
        seen = 1'b0;
        while (!seen) begin
            #2;
            seen = use_lsu ? lsu_arready : fetch_arready;   // Transfer on the coming edge
            next_cycle();
        end
        lsu_arvalid   = use_lsu ? 1'b0 : lsu_arvalid;
        fetch_arvalid = use_lsu ? fetch_arvalid : 1'b0;
        seen = 1'b0;
        while (!seen) begin
            #2;
            seen = use_lsu ? lsu_rvalid : fetch_rvalid;
            next_cycle();
        end
        repeat (hold) next_cycle();                     // Back-pressure
        if (use_lsu) begin
            lsu_rready = 1'b1;
        end else begin
            fetch_rready = 1'b1;
        end
        #2;
        data = use_lsu ? lsu_rdata : fetch_rdata;
        resp = use_lsu ? lsu_rresp : fetch_rresp;
        next_cycle();
        lsu_rready   = use_lsu ? 1'b0 : lsu_rready;
        fetch_rready = use_lsu ? fetch_rready : 1'b0;
    endtask

    task automatic write_txn(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                             input int hold, output axi_resp_t resp);
        logic seen;
        lsu_awvalid = 1'b1;                             // aw and w presented together
        lsu_awaddr  = addr;
        lsu_wvalid  = 1'b1;
        lsu_wdata   = data;
        lsu_wstrb   = strb;
        seen = 1'b0;
        while (!seen) begin
            #2;
            seen = lsu_awready && lsu_wready;
            next_cycle();
        end
        lsu_awvalid = 1'b0;
        lsu_wvalid  = 1'b0;
        seen = 1'b0;
        while (!seen) begin
            #2;
            seen = lsu_bvalid;
            next_cycle();
        end
        repeat (hold) next_cycle();
        lsu_bready = 1'b1;
        #2;
        resp = lsu_bresp;
        next_cycle();
        lsu_bready = 1'b0;
    endtask

    task automatic report_test(input int n, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("test %0d %s %08h: ok", n,
                     pat_field(n, 1) == 1 ? "write" : "read", pat_field(n, 2));
        end else begin
            failed++;
            $display("test %0d %s %08h: failed", n,
                     pat_field(n, 1) == 1 ? "write" : "read", pat_field(n, 2));
        end
    endtask

    task automatic run_single(input int n);
        logic [31:0] mgr;
        logic [31:0] op;
        logic        flag;
        int          hold;
        int          errs_before;
        int          tx_before;
        axi_data_t   got_data;
        axi_resp_t   got_resp;
        mgr         = pat_field(n, 0);
        op          = pat_field(n, 1);
        flag        = pat_field(n, 6) != 0;             // Range check or UART byte
        hold        = next_hold();
        errs_before = errors;
        tx_before   = tx_count;
        if (op == 1 && mgr != 1) begin
            errors++;
            $display("Pattern %0d asks the read-only fetch port to write", n);
        end else if (op == 1) begin
            write_txn(pat_field(n, 2), pat_field(n, 3), axi_strb_t'(pat_field(n, 4)),
                      hold, got_resp);
            check_resp("lsu_bresp", got_resp, axi_resp_t'(pat_field(n, 7)));
            check_tx(flag, uart_byte_t'(pat_field(n, 5)), tx_before);
        end else begin
            read_txn(mgr == 1, pat_field(n, 2), hold, got_data, got_resp);
            check_data(mgr == 1 ? "lsu_rdata" : "fetch_rdata", got_data, pat_field(n, 5),
                       flag ? 40 : 0);
            check_resp(mgr == 1 ? "lsu_rresp" : "fetch_rresp", got_resp,
                       axi_resp_t'(pat_field(n, 7)));
            check_tx(1'b0, 8'h00, tx_before);           // Reads never strobe the UART
        end
        report_test(n, errs_before);
    endtask

    // Fetch read on line n and lsu read on line n+1, issued in the same cycle
    task automatic run_pair(input int n);
        int        hold_f;
        int        hold_l;
        int        errs_before;
        int        tx_before;
        axi_data_t data_f;
        axi_data_t data_l;
        axi_resp_t resp_f;
        axi_resp_t resp_l;
        hold_f      = next_hold();
        hold_l      = next_hold();
        errs_before = errors;
        tx_before   = tx_count;
        if (pat_field(n, 0) != 0 || pat_field(n + 1, 0) != 1 || pat_field(n + 1, 1) != 0) begin
            errors++;
            $display("Pattern %0d: a paired read needs fetch first and an lsu read next", n);
            report_test(n, errs_before);
            report_test(n + 1, errs_before);
        end else begin
            fork
                read_txn(1'b0, pat_field(n, 2), hold_f, data_f, resp_f);
                read_txn(1'b1, pat_field(n + 1, 2), hold_l, data_l, resp_l);
            join
            check_data("fetch_rdata", data_f, pat_field(n, 5), pat_field(n, 6) != 0 ? 40 : 0);
            check_resp("fetch_rresp", resp_f, axi_resp_t'(pat_field(n, 7)));
            report_test(n, errs_before);
            errs_before = errors;
            check_data("lsu_rdata", data_l, pat_field(n + 1, 5),
                       pat_field(n + 1, 6) != 0 ? 40 : 0);
            check_resp("lsu_rresp", resp_l, axi_resp_t'(pat_field(n + 1, 7)));
            check_tx(1'b0, 8'h00, tx_before);
            report_test(n + 1, errs_before);
        end
    endtask

    initial begin
        rst           = 1'b1;
        fetch_arvalid = 1'b0;
        fetch_araddr  = '0;
        fetch_rready  = 1'b0;
        lsu_arvalid   = 1'b0;
        lsu_araddr    = '0;
        lsu_rready    = 1'b0;
        lsu_awvalid   = 1'b0;
        lsu_awaddr    = '0;
        lsu_wvalid    = 1'b0;
        lsu_wdata     = '0;
        lsu_wstrb     = '0;
        lsu_bready    = 1'b0;
        lcg_state     = 32'h9bfb2f9a;
        $readmemh("bench/soc_patterns.mem", pats);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        if ($isunknown(pats[NUM_PATS*FIELDS-1])) begin
            errors++;
            $display("Pattern file bench/soc_patterns.mem is missing or shorter than %0d lines",
                     NUM_PATS);
        end else begin
            idx = 0;
            while (idx < NUM_PATS) begin
                if (pat_field(idx, 1) == 32'd2) begin
                    run_pair(idx);
                    idx += 2;
                end else begin
                    run_single(idx);
                    idx += 1;
                end
            end
        end
        $display("Tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- bench/soc_patterns.mem
// mgr (0 fetch, 1 lsu)  op (0 read, 1 write, 2 read issued with next line)  addr  wdata  strb
// expected data  flag (read: accept up to expected+40, write: one UART byte)  resp (0 ok, 3 decerr)
1 1 80000010 11223344 f 00000000 0 0
1 1 80000010 aabbccdd 5 00000000 0 0
0 0 80000010 00000000 0 11bb33dd 0 0
1 0 80000010 00000000 0 11bb33dd 0 0
1 1 80001000 5a5aa5a5 f 00000000 0 0
0 0 80000000 00000000 0 5a5aa5a5 0 0
1 1 a00003f8 00000041 1 00000041 1 0
1 1 a00003f8 00004200 2 00000000 0 0
1 0 a00003f8 00000000 0 00000020 0 0
1 1 a0000048 00001000 f 00000000 0 0
1 0 a0000048 00000000 0 00001000 1 0
0 0 a000004c 00000000 0 00000000 0 0
1 0 40000000 00000000 0 00000000 0 3
1 1 40000000 00000041 f 00000000 0 3
1 1 80000020 01020304 f 00000000 0 0
1 1 80000024 0badf00d f 00000000 0 0
0 2 80000020 00000000 0 01020304 0 0
1 0 80000024 00000000 0 0badf00d 0 0
0 2 80000024 00000000 0 0badf00d 0 0
1 0 80000020 00000000 0 01020304 0 0

//--- sources.f
common/soc_pkg.sv
xbar/axil_read_mux.sv
xbar/axil_write_mux.sv
design/sram_dev.sv
design/clint_dev.sv
design/uart_dev.sv
design/soc_top.sv
bench/tb_soc_top.sv

//--- Makefile
SRCS := $(shell grep -v '^+' sources.f)

.PHONY: run clean

run: obj_dir/Vtb_soc_top
	@out="$$(./obj_dir/Vtb_soc_top)"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

obj_dir/Vtb_soc_top: sources.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_soc_top -f sources.f

clean:
	rm -rf obj_dir
